// ==== core_params.svh ====
// core configuration macros
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define CORE_XLEN 64

// first fetch address after reset
`define CORE_PC_START 0

// architectural integer registers
`define CORE_NREGS 32

// custom opcodes kept from the difftest core
// putch prints a0[7:0]
`define CORE_OPC_PUTCH 7'h7b
// trap halts with code a0[7:0]
`define CORE_OPC_TRAP 7'h6b

`endif

// ==== core_pkg.sv ====
// core shared types
`default_nettype none
`include "core_params.svh"

package core_pkg;

  // decoded operations
  typedef enum logic [3:0] {
    OP_ADDI,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_LUI,
    OP_BNE,
    OP_PUTCH,
    OP_TRAP,
    OP_ILLEGAL
  } op_e;

  // one state per instruction phase and a halt state
  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_WB,
    ST_HALT
  } state_e;

endpackage

`default_nettype wire

// ==== reg_port_if.sv ====
// register file port bundle
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

interface reg_port_if;

  logic [$clog2(`CORE_NREGS)-1:0] rs1_addr;
  logic [$clog2(`CORE_NREGS)-1:0] rs2_addr;
  logic [`CORE_XLEN-1:0]          rs1_data;
  logic [`CORE_XLEN-1:0]          rs2_data;
  logic [$clog2(`CORE_NREGS)-1:0] rd_addr;
  logic                           rd_wen;
  logic [`CORE_XLEN-1:0]          rd_wdata;

  modport exec (
    output rs1_addr, rs2_addr, rd_addr, rd_wen, rd_wdata,
    input  rs1_data, rs2_data
  );

  modport regfile (
    input  rs1_addr, rs2_addr, rd_addr, rd_wen, rd_wdata,
    output rs1_data, rs2_data
  );

endinterface

`default_nettype wire

// ==== core_ctrl.sv ====
// multi-cycle core controller
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_ctrl (
  input  logic          clock_i,
  input  logic          reset_i,
  input  core_pkg::op_e op_i,
  output logic          fetch_en_o,
  output logic          exec_en_o,
  output logic          wb_en_o,
  output logic          halted_o
);

  core_pkg::state_e state_q;
  core_pkg::state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::ST_FETCH: begin
        state_d = core_pkg::ST_EXEC;
      end
      core_pkg::ST_EXEC: begin
        state_d = core_pkg::ST_WB;
      end
      core_pkg::ST_WB: begin
        // trap and unknown opcodes stop the core for good
        if (op_i == core_pkg::OP_TRAP || op_i == core_pkg::OP_ILLEGAL) begin
          state_d = core_pkg::ST_HALT;
        end else begin
          state_d = core_pkg::ST_FETCH;
        end
      end
      core_pkg::ST_HALT: begin
        state_d = core_pkg::ST_HALT;
      end
      default: begin
        state_d = core_pkg::ST_HALT;
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= core_pkg::ST_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // one-hot stage strobes
  assign fetch_en_o = (state_q == core_pkg::ST_FETCH);
  assign exec_en_o  = (state_q == core_pkg::ST_EXEC);
  assign wb_en_o    = (state_q == core_pkg::ST_WB);
  assign halted_o   = (state_q == core_pkg::ST_HALT);

endmodule

`default_nettype wire

// ==== perf_counter.sv ====
// cycle and retire counters
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module perf_counter (
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic                  halted_i,
  input  logic                  retire_i,
  output logic [`CORE_XLEN-1:0] cycle_count_o,
  output logic [`CORE_XLEN-1:0] instr_count_o
);

  logic [`CORE_XLEN-1:0] cycle_q;
  logic [`CORE_XLEN-1:0] instr_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      cycle_q <= '0;
      instr_q <= '0;
    end else begin
      // frozen once the core halts
      if (!halted_i) begin
        cycle_q <= cycle_q + `CORE_XLEN'(1);
      end
      if (retire_i) begin
        instr_q <= instr_q + `CORE_XLEN'(1);
      end
    end
  end

  assign cycle_count_o = cycle_q;
  assign instr_count_o = instr_q;

endmodule

`default_nettype wire

// ==== regfile.sv ====
// integer register file
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module regfile (
  input  logic       clock_i,
  input  logic       reset_i,
  reg_port_if.regfile rp
);

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NREGS];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rp.rd_wen && rp.rd_addr != '0) begin
      // x0 writes are dropped here
      regs_q[rp.rd_addr] <= rp.rd_wdata;
    end
  end

  // combinational reads with x0 hardwired to zero
  always_comb begin
    if (rp.rs1_addr == '0) begin
      rp.rs1_data = '0;
    end else begin
      rp.rs1_data = regs_q[rp.rs1_addr];
    end
  end

  always_comb begin
    if (rp.rs2_addr == '0) begin
      rp.rs2_data = '0;
    end else begin
      rp.rs2_data = regs_q[rp.rs2_addr];
    end
  end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
// fetch, decode and execute datapath
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module exec_unit (
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic                  fetch_en_i,
  input  logic                  exec_en_i,
  input  logic                  wb_en_i,
  output logic [`CORE_XLEN-1:0] imem_addr_o,
  input  logic [31:0]           imem_data_i,
  output core_pkg::op_e         op_o,
  reg_port_if.exec              rp,
  output logic                  uart_valid_o,
  output logic [7:0]            uart_ch_o,
  output logic [7:0]            trap_code_o
);

  localparam int unsigned AW = $clog2(`CORE_NREGS);
  localparam logic [AW-1:0] REG_A0 = AW'(10);

  logic [`CORE_XLEN-1:0] pc_q;
  logic [31:0]           ir_q;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] alu_res;
  logic [`CORE_XLEN-1:0] res_q;
  logic                  take_q;
  logic                  writes_rd;
  core_pkg::op_e         op;

  assign imm_i = {{(`CORE_XLEN-12){ir_q[31]}}, ir_q[31:20]};
  assign imm_u = {{(`CORE_XLEN-32){ir_q[31]}}, ir_q[31:12], 12'b0};
  assign imm_b = {{(`CORE_XLEN-13){ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25],
                  ir_q[11:8], 1'b0};

  always_comb begin
    op = core_pkg::OP_ILLEGAL;
    case (ir_q[6:0])
      7'h13: begin
        case (ir_q[14:12])
          3'b000: op = core_pkg::OP_ADDI;
          3'b100: op = core_pkg::OP_XORI;
          3'b110: op = core_pkg::OP_ORI;
          3'b111: op = core_pkg::OP_ANDI;
          default: op = core_pkg::OP_ILLEGAL;
        endcase
      end
      7'h33: begin
        if (ir_q[31:25] == 7'b0100000 && ir_q[14:12] == 3'b000) begin
          op = core_pkg::OP_SUB;
        end else if (ir_q[31:25] == 7'b0000000) begin
          case (ir_q[14:12])
            3'b000: op = core_pkg::OP_ADD;
            3'b100: op = core_pkg::OP_XOR;
            3'b110: op = core_pkg::OP_OR;
            3'b111: op = core_pkg::OP_AND;
            default: op = core_pkg::OP_ILLEGAL;
          endcase
        end
      end
      7'h37: op = core_pkg::OP_LUI;
      7'h63: begin
        if (ir_q[14:12] == 3'b001) begin
          op = core_pkg::OP_BNE;
        end
      end
      `CORE_OPC_PUTCH: op = core_pkg::OP_PUTCH;
      `CORE_OPC_TRAP: op = core_pkg::OP_TRAP;
      default: op = core_pkg::OP_ILLEGAL;
    endcase
  end

  always_comb begin
    case (op)
      core_pkg::OP_ADDI: alu_res = rp.rs1_data + imm_i;
      core_pkg::OP_XORI: alu_res = rp.rs1_data ^ imm_i;
      core_pkg::OP_ORI:  alu_res = rp.rs1_data | imm_i;
      core_pkg::OP_ANDI: alu_res = rp.rs1_data & imm_i;
      core_pkg::OP_ADD:  alu_res = rp.rs1_data + rp.rs2_data;
      core_pkg::OP_SUB:  alu_res = rp.rs1_data - rp.rs2_data;
      core_pkg::OP_XOR:  alu_res = rp.rs1_data ^ rp.rs2_data;
      core_pkg::OP_OR:   alu_res = rp.rs1_data | rp.rs2_data;
      core_pkg::OP_AND:  alu_res = rp.rs1_data & rp.rs2_data;
      core_pkg::OP_LUI:  alu_res = imm_u;
      default:           alu_res = '0;
    endcase
  end

  assign writes_rd = op inside {core_pkg::OP_ADDI, core_pkg::OP_XORI, core_pkg::OP_ORI,
                                core_pkg::OP_ANDI, core_pkg::OP_ADD, core_pkg::OP_SUB,
                                core_pkg::OP_XOR, core_pkg::OP_OR, core_pkg::OP_AND,
                                core_pkg::OP_LUI};

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pc_q        <= `CORE_XLEN'(`CORE_PC_START);
      ir_q        <= '0;
      take_q      <= 1'b0;
      trap_code_o <= '0;
    end else begin
      if (fetch_en_i) begin
        ir_q <= imem_data_i;
      end
      if (exec_en_i) begin
        take_q <= (op == core_pkg::OP_BNE) && (rp.rs1_data != rp.rs2_data);
      end
      if (wb_en_i) begin
        pc_q <= take_q ? pc_q + imm_b : pc_q + `CORE_XLEN'(4);
        if (op == core_pkg::OP_TRAP) begin
          trap_code_o <= rp.rs1_data[7:0];
        end else if (op == core_pkg::OP_ILLEGAL) begin
          trap_code_o <= 8'hff;
        end
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (exec_en_i) begin
      res_q <= alu_res;
    end
  end

  // putch and trap both read a0 through port 1
  assign rp.rs1_addr = (op == core_pkg::OP_PUTCH || op == core_pkg::OP_TRAP) ?
                       REG_A0 : ir_q[19:15];
  assign rp.rs2_addr = ir_q[24:20];
  assign rp.rd_addr  = ir_q[11:7];
  assign rp.rd_wen   = wb_en_i & writes_rd;
  assign rp.rd_wdata = res_q;

  assign imem_addr_o  = pc_q;
  assign op_o         = op;
  assign uart_valid_o = wb_en_i && (op == core_pkg::OP_PUTCH);
  assign uart_ch_o    = uart_valid_o ? rp.rs1_data[7:0] : 8'h00;

endmodule

`default_nettype wire

// ==== core_top.sv ====
// rv64 multi-cycle core top
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_top (
  input  logic                  clock,
  input  logic                  reset,

  output logic [`CORE_XLEN-1:0] imem_addr_o,
  input  logic [31:0]           imem_data_i,

  output logic                  uart_valid_o,
  output logic [7:0]            uart_ch_o,

  output logic                  halted_o,
  output logic [7:0]            trap_code_o,

  output logic [`CORE_XLEN-1:0] cycle_count_o,
  output logic [`CORE_XLEN-1:0] instr_count_o
);

  logic          fetch_en;
  logic          exec_en;
  logic          wb_en;
  core_pkg::op_e op;

  reg_port_if rp ();

  core_ctrl u_ctrl (
    .clock_i    (clock),
    .reset_i    (reset),
    .op_i       (op),
    .fetch_en_o (fetch_en),
    .exec_en_o  (exec_en),
    .wb_en_o    (wb_en),
    .halted_o   (halted_o)
  );

  exec_unit u_exec (
    .clock_i      (clock),
    .reset_i      (reset),
    .fetch_en_i   (fetch_en),
    .exec_en_i    (exec_en),
    .wb_en_i      (wb_en),
    .imem_addr_o  (imem_addr_o),
    .imem_data_i  (imem_data_i),
    .op_o         (op),
    .rp           (rp.exec),
    .uart_valid_o (uart_valid_o),
    .uart_ch_o    (uart_ch_o),
    .trap_code_o  (trap_code_o)
  );

  regfile u_regfile (
    .clock_i (clock),
    .reset_i (reset),
    .rp      (rp.regfile)
  );

  // every write-back retires one instruction
  perf_counter u_perf (
    .clock_i       (clock),
    .reset_i       (reset),
    .halted_i      (halted_o),
    .retire_i      (wb_en),
    .cycle_count_o (cycle_count_o),
    .instr_count_o (instr_count_o)
  );

endmodule

`default_nettype wire

// ==== core_assertions.sv ====
// core protocol assertions
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_assertions (
  input logic                  clock_i,
  input logic                  reset_i,
  input logic [`CORE_XLEN-1:0] imem_addr_i,
  input logic                  uart_valid_i,
  input logic                  halted_i,
  input logic [`CORE_XLEN-1:0] cycle_count_i
);

  // read by the testbench top
  int fail_count = 0;

  // a halted core prints nothing
  assert property (@(posedge clock_i) disable iff (reset_i) !(uart_valid_i && halted_i))
    else begin
      $error("uart_valid_o high while halted_o is high");
      fail_count++;
    end

  // halt is sticky until reset
  assert property (@(posedge clock_i) disable iff (reset_i) halted_i |=> halted_i)
    else begin
      $error("halted_o fell outside reset");
      fail_count++;
    end

  assert property (@(posedge clock_i) disable iff (reset_i) imem_addr_i[1:0] == 2'b00)
    else begin
      $error("imem_addr_o not word aligned");
      fail_count++;
    end

  assert property (@(posedge clock_i) disable iff (reset_i)
                   halted_i |=> $stable(cycle_count_i))
    else begin
      $error("cycle_count_o moved while halted");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== core_tb.sv ====
// core testbench
`timescale 1ns/1ps
`default_nettype none
`include "core_params.svh"

module core_tb;

  localparam int ROM_WORDS = 256;

  logic                  clock;
  logic                  reset;
  logic [`CORE_XLEN-1:0] imem_addr;
  logic [31:0]           imem_data;
  logic                  uart_valid;
  logic [7:0]            uart_ch;
  logic                  halted;
  logic [7:0]            trap_code;
  logic [`CORE_XLEN-1:0] cycle_count;
  logic [`CORE_XLEN-1:0] instr_count;

  logic [31:0]           rom [ROM_WORDS];
  logic [7:0]            uart_exp [$];
  logic [7:0]            trap_exp;
  logic [`CORE_XLEN-1:0] count_exp;
  int                    uart_seen;
  int                    cycles;
  int                    cycle_limit;

  core_top uut (
    .clock         (clock),
    .reset         (reset),
    .imem_addr_o   (imem_addr),
    .imem_data_i   (imem_data),
    .uart_valid_o  (uart_valid),
    .uart_ch_o     (uart_ch),
    .halted_o      (halted),
    .trap_code_o   (trap_code),
    .cycle_count_o (cycle_count),
    .instr_count_o (instr_count)
  );

  bind core_top core_assertions u_assert (
    .clock_i       (clock),
    .reset_i       (reset),
    .imem_addr_i   (imem_addr_o),
    .uart_valid_i  (uart_valid_o),
    .halted_i      (halted_o),
    .cycle_count_i (cycle_count_o)
  );

  always #5 clock = ~clock;

  // program ROM answers zero outside the image
  assign imem_data = ((imem_addr >> 2) < ROM_WORDS) ? rom[imem_addr[9:2]] : 32'h0;

  task automatic report_failure(input string msg);
    $display("ERROR: %s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    int          c;
    int          word_addr;
    bit          done;
    logic [7:0]  tag;
    logic [31:0] value;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    trap_exp = '0;
    count_exp = '0;
    word_addr = 0;
    done = 1'b0;
    fd = $fopen("core_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open core_stimulus.txt");
    end else begin
      while (!done) begin
        n = $fscanf(fd, " %c", tag);
        if (n != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          // skip the rest of a comment
          c = $fgetc(fd);
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          n = $fscanf(fd, " %h", value);
          if (n != 1) begin
            report_failure("stimulus line has no hex value");
          end else begin
            case (tag)
              "I": begin
                rom[word_addr] = value;
                word_addr++;
              end
              "U": uart_exp.push_back(value[7:0]);
              "T": trap_exp = value[7:0];
              "C": count_exp = value;
              default: report_failure("unknown tag in stimulus file");
            endcase
          end
        end
      end
      $fclose(fd);
    end
    if (count_exp == 0) begin
      report_failure("stimulus file gives no instruction count");
    end
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #1;
    reset = 1'b1;
    uart_seen = 0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    cycles = 0;
  endtask

  task automatic check_reset_state();
    @(negedge clock);
    check_value("halted_o", halted, 1'b0);
    check_value("uart_valid_o", uart_valid, 1'b0);
    check_value("cycle_count_o", cycle_count, 0);
    check_value("instr_count_o", instr_count, 0);
    check_value("imem_addr_o", imem_addr, `CORE_PC_START);
  endtask

  task automatic run_to_halt();
    while (halted !== 1'b1) begin
      @(negedge clock);
    end
    check_value("trap_code_o", trap_code, trap_exp);
    check_value("instr_count_o", instr_count, count_exp);
    check_value("cycle_count_o", cycle_count, 3 * count_exp);
    // stray UART pulses after halt show up here
    repeat (10) @(negedge clock);
    check_value("uart pulse count", uart_seen, uart_exp.size());
    check_value("halted_o", halted, 1'b1);
  endtask

  // UART byte monitor
  always @(negedge clock) begin
    if (!reset && uart_valid) begin
      if (uart_seen >= uart_exp.size()) begin
        report_failure("more UART bytes than the stimulus file expects");
      end else begin
        check_value("uart_ch_o", uart_ch, uart_exp[uart_seen]);
      end
      uart_seen++;
    end
    if (uut.u_assert.fail_count != 0) begin
      report_failure("a protocol assertion on core_top failed");
    end
  end

  always @(posedge clock) begin
    if (!reset) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
        report_failure($sformatf("core did not halt within %0d cycles", cycle_limit));
      end
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    uart_seen = 0;
    cycles = 0;
    cycle_limit = 50;
    load_stimulus();
    cycle_limit = 3 * int'(count_exp) + 50;

    apply_reset();
    check_reset_state();
    run_to_halt();

    // second reset reruns the same program
    apply_reset();
    check_reset_state();
    run_to_halt();

    if (uut.u_assert.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
core_pkg.sv
reg_port_if.sv
core_ctrl.sv
perf_counter.sv
regfile.sv
exec_unit.sv
core_top.sv
core_assertions.sv
core_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_mc_core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - reg_port_if.sv
      - core_ctrl.sv
      - perf_counter.sv
      - regfile.sv
      - exec_unit.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_assertions.sv
      - core_tb.sv

// ==== core_stimulus.txt ====
# tag and hex value: I program word in address order, U expected UART byte
# T expected trap code, C expected retired instructions at halt
I 04800513  # addi a0, x0, 0x48
I 0000007b  # putch
I 02154513  # xori a0, a0, 0x21
I 0000007b
I 00656513  # ori a0, a0, 0x06
I 0000007b
I 03c57513  # andi a0, a0, 0x3c
I 0000007b
I 01300293  # addi t0, x0, 0x13
I 00550533  # add a0, a0, t0
I 0000007b
I 40a28533  # sub a0, t0, a0
I 0000007b
I 00554533  # xor a0, a0, t0
I 0000007b
I 00556533  # or a0, a0, t0
I 0000007b
I 00557533  # and a0, a0, t0
I 0000007b
I 12345537  # lui a0, 0x12345
I 04a50513  # addi a0, a0, 0x4a
I 0000007b
I 05550013  # addi x0, a0, 0x55
I 00000533  # add a0, x0, x0
I 0000007b
I 00300293  # addi t0, x0, 3
I 02a00513  # addi a0, x0, 0x2a
I 0000007b  # loop: putch
I fff28293  # addi t0, t0, -1
I fe029ce3  # bne t0, x0, loop
I 00529463  # bne t0, t0, +8 falls through
I 05a00513  # addi a0, x0, 0x5a
I 0000007b
I 03c00513  # addi a0, x0, 0x3c
I 0000006b  # trap
U 48
U 69
U 6f
U 2c
U 3f
U d4
U c7
U d7
U 13
U 4a
U 00
U 2a
U 2a
U 2a
U 5a
T 3c
C 29
